/* build.f */
hdl/hv_cfg_pkg.sv
hdl/hv_reg_pkg.sv
hdl/hv_reg_if.sv
hdl/hv_owt_rx.sv
hdl/hv_reg_arb.sv
hdl/hv_reg_bank.sv
hdl/hv_lbist.sv
hdl/hv_digital_top.sv
dv/hv_checker.sv
dv/tb_hv_digital.sv

/* dv/hv_checker.sv */
// checker module for reset state, frame status and bist results against expected values
`timescale 1ns/1ps

module hv_checker (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_bist_en,
    input  logic i_bist_done,
    input  logic i_owt_fail,
    input  logic i_scan_fail,
    input  logic i_rx_done,
    input  logic i_rx_bad,
    input  int   i_test_id,
    input  logic i_exp_owt_fail,
    input  logic i_exp_scan_fail,
    input  logic i_exp_rx_bad,
    input  int   i_frames_sent,
    output int   o_err_cnt,
    output int   o_test_cnt
);

    int   err_cnt     = 0;
    int   test_cnt    = 0;
    int   test_errs   = 0;
    int   rx_cnt      = 0;
    logic rst_checked = 1'b0;
    logic done_q      = 1'b0;
    logic en_q        = 1'b0;
    logic clr_pend    = 1'b0;

    assign o_err_cnt  = err_cnt;
    assign o_test_cnt = test_cnt;

    function automatic string test_name(input int id);
        case (id)
            0:       test_name = "reset";
            1:       test_name = "bist_pass";
            2:       test_name = "link_fail";
            3:       test_name = "rerun_pass";
            4:       test_name = "scan_fail";
            5:       test_name = "scan_clear";
            6:       test_name = "random_mix";
            default: test_name = "unknown";
        endcase
    endfunction

    task automatic compare(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s: %s expected %0b actual %0b", test_name(i_test_id), what, exp, act);
            err_cnt++;
            test_errs++;
        end
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            $display("test %s: pass", test_name(i_test_id));
        end else begin
            $display("test %s: %0d mismatches", test_name(i_test_id), test_errs);
        end
        test_cnt++;
        test_errs = 0;
    endtask

    // sampled on the rising edge before the dut outputs update
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            rst_checked = 1'b0;
        end else if (!rst_checked) begin
            // first edge after release still shows the reset values
            rst_checked = 1'b1;
            compare("o_bist_done", 1'b0, i_bist_done);
            compare("o_owt_bist_fail", 1'b0, i_owt_fail);
            compare("o_scan_bist_fail", 1'b0, i_scan_fail);
            compare("o_rx_done", 1'b0, i_rx_done);
            compare("o_rx_bad", 1'b0, i_rx_bad);
            report_test();
        end

        // ====================
        // per frame
        // ====================
        if (i_rx_done) begin
            rx_cnt++;
            compare("o_rx_bad", i_exp_rx_bad, i_rx_bad);
        end

        // one edge after disable everything reads low
        if (clr_pend) begin
            compare("o_bist_done after disable", 1'b0, i_bist_done);
            compare("o_owt_bist_fail after disable", 1'b0, i_owt_fail);
            compare("o_scan_bist_fail after disable", 1'b0, i_scan_fail);
            clr_pend = 1'b0;
        end
        if (!i_bist_en && en_q) begin
            clr_pend = 1'b1;
        end

        // ====================
        // bist result
        // ====================
        if (i_bist_done && !done_q) begin
            compare("o_owt_bist_fail", i_exp_owt_fail, i_owt_fail);
            compare("o_scan_bist_fail", i_exp_scan_fail, i_scan_fail);
            if (rx_cnt != i_frames_sent) begin
                $display("%s: %0d frames were sent but %0d rx_done pulses were seen",
                         test_name(i_test_id), i_frames_sent, rx_cnt);
                err_cnt++;
                test_errs++;
            end
            report_test();
        end
        done_q = i_bist_done;
        en_q   = i_bist_en;
    end

endmodule

/* dv/tb_hv_digital.sv */
// testbench top with clock, reset, frame driver, bist runs, register model and watchdog
`timescale 1ns/1ps

module tb_hv_digital;

    localparam int NUM_TESTS = 7;
    localparam int REG_NUM   = hv_cfg_pkg::HV_SCAN_REG_NUM;
    localparam int BIT_CLKS  = hv_cfg_pkg::OWT_BIT_CLKS;
    localparam int OK_NUM    = hv_cfg_pkg::BIST_OWT_RX_OK_NUM;
    localparam int TMO_TH    = hv_cfg_pkg::BIST_TMO_TH;
    localparam int ADDR_W    = hv_reg_pkg::REG_ADDR_W;
    localparam int DATA_W    = hv_reg_pkg::REG_DATA_W;
    // twice the window plus ten 16-bit frames per test at 8 ns
    localparam int WDOG_NS   = 2 * NUM_TESTS * (TMO_TH + 10 * 16 * BIT_CLKS) * 8;

    logic clk = 1'b0;
    logic rst_n;
    logic owt_rx;
    logic bist_en;
    logic bist_done;
    logic owt_fail;
    logic scan_fail;
    logic rx_done;
    logic rx_bad;
    logic exp_owt_fail;
    logic exp_scan_fail;
    logic exp_rx_bad;
    int   seed = 32'h311900e3;
    int   test_id;
    int   frames_sent;
    int   tb_errs;
    int   chk_errs;
    int   tests_done;
    // per register flag that the stored check bit matches the data
    logic model_ok [REG_NUM];

    always #4 clk = ~clk;

    hv_digital_top hv_digital_top_inst (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_owt_rx         (owt_rx),
        .i_bist_en        (bist_en),
        .o_owt_bist_fail  (owt_fail),
        .o_scan_bist_fail (scan_fail),
        .o_bist_done      (bist_done),
        .o_rx_done        (rx_done),
        .o_rx_bad         (rx_bad)
    );

    hv_checker hv_checker_inst (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_bist_en       (bist_en),
        .i_bist_done     (bist_done),
        .i_owt_fail      (owt_fail),
        .i_scan_fail     (scan_fail),
        .i_rx_done       (rx_done),
        .i_rx_bad        (rx_bad),
        .i_test_id       (test_id),
        .i_exp_owt_fail  (exp_owt_fail),
        .i_exp_scan_fail (exp_scan_fail),
        .i_exp_rx_bad    (exp_rx_bad),
        .i_frames_sent   (frames_sent),
        .o_err_cnt       (chk_errs),
        .o_test_cnt      (tests_done)
    );

    function automatic int rand_below(input int n);
        rand_below = int'($unsigned($random(seed)) % n);
    endfunction

    task automatic hold_line(input logic level);
        owt_rx = level;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    // ====================
    // frame driver
    // ====================
    task automatic send_frame(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic chk_good, input logic corrupt);
        logic                                chk;
        logic                                par;
        logic                                stop;
        logic [hv_cfg_pkg::OWT_FRAME_BITS-1:0] bits;
        chk  = chk_good ? ^data : ~^data;
        par  = ^{addr, data, chk};
        stop = 1'b1;
        if (corrupt) begin
            if (rand_below(2) == 0) begin
                par = ~par;
            end else begin
                stop = 1'b0;
            end
        end
        bits       = {addr, data, chk, par, stop};
        exp_rx_bad = corrupt;
        hold_line(1'b0);
        for (int i = hv_cfg_pkg::OWT_FRAME_BITS - 1; i >= 0; i--) begin
            hold_line(bits[i]);
        end
        // one idle bit closes the 16-bit slot
        hold_line(1'b1);
        if (!corrupt) begin
            model_ok[addr] = chk_good;
        end
        frames_sent++;
    endtask

    task automatic run_bist(input int id, input int n_good, input int n_bad);
        int                good_left;
        int                bad_left;
        int                waited;
        logic [ADDR_W-1:0] addr;
        good_left     = n_good;
        bad_left      = n_bad;
        waited        = 0;
        test_id       = id;
        exp_owt_fail  = (n_good < OK_NUM);
        exp_scan_fail = 1'b0;
        for (int i = 0; i < REG_NUM; i++) begin
            if (!model_ok[i]) begin
                exp_scan_fail = 1'b1;
            end
        end
        bist_en = 1'b1;
        while (good_left + bad_left > 0) begin
            addr = ADDR_W'(rand_below(REG_NUM));
            if (rand_below(good_left + bad_left) < bad_left) begin
                send_frame(addr, DATA_W'(rand_below(256)), rand_below(2) == 0, 1'b1);
                bad_left--;
            end else begin
                // good frames reuse the register's check state
                send_frame(addr, DATA_W'(rand_below(256)), model_ok[addr], 1'b0);
                good_left--;
            end
        end
        while (!bist_done && waited < 2 * TMO_TH) begin
            @(negedge clk);
            waited++;
        end
        if (!bist_done) begin
            $display("bist done never rose in test %0d", id);
            tb_errs++;
        end
        repeat (4) @(negedge clk);
        bist_en = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        logic [ADDR_W-1:0] bad_addr;
        int                n_good;
        owt_rx        = 1'b1;
        bist_en       = 1'b0;
        rst_n         = 1'b0;
        exp_owt_fail  = 1'b0;
        exp_scan_fail = 1'b0;
        exp_rx_bad    = 1'b0;
        test_id       = 0;
        frames_sent   = 0;
        tb_errs       = 0;
        for (int i = 0; i < REG_NUM; i++) begin
            model_ok[i] = 1'b1;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (8) @(negedge clk);

        run_bist(1, OK_NUM + rand_below(4), rand_below(2));
        // corrupt frames keep the good count short
        run_bist(2, rand_below(OK_NUM), 1 + rand_below(4));
        run_bist(3, OK_NUM + rand_below(4), 0);

        bad_addr = ADDR_W'(rand_below(REG_NUM));
        send_frame(bad_addr, DATA_W'(rand_below(256)), 1'b0, 1'b0);
        run_bist(4, OK_NUM + rand_below(3), rand_below(3));

        // repair the register before a corrupt frame with a wrong check bit
        send_frame(bad_addr, DATA_W'(rand_below(256)), 1'b1, 1'b0);
        send_frame(ADDR_W'(rand_below(REG_NUM)), DATA_W'(rand_below(256)), 1'b0, 1'b1);
        run_bist(5, OK_NUM + rand_below(3), rand_below(3));

        n_good = rand_below(8);
        send_frame(ADDR_W'(rand_below(REG_NUM)), DATA_W'(rand_below(256)),
                   rand_below(2) == 0, 1'b0);
        run_bist(6, n_good, rand_below(3));

        repeat (8) @(negedge clk);
        if (tests_done != NUM_TESTS) begin
            $display("only %0d of %0d tests reported a result", tests_done, NUM_TESTS);
        end
        $display("tests %0d of %0d, errors %0d", tests_done, NUM_TESTS, tb_errs + chk_errs);
        if (tb_errs + chk_errs == 0 && tests_done == NUM_TESTS) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WDOG_NS);
        $display("watchdog expired after %0d ns and the run did not finish", WDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* hdl/hv_cfg_pkg.sv */
// package: bist window, link frame count and one-wire bit timing constants
package hv_cfg_pkg;

    // ====================
    // register scan
    // ====================
    localparam int HV_SCAN_REG_NUM    = 8;

    // ====================
    // bist window
    // ====================
    // window length in clock cycles
    localparam int BIST_TMO_TH        = 2000;
    localparam int BIST_TMO_CNT_W     = 11;
    // good frames needed before the window closes
    localparam int BIST_OWT_RX_OK_NUM = 4;
    localparam int BIST_OWT_RX_CNT_W  = 8;

    // one-wire line, bits after the start bit
    localparam int OWT_BIT_CLKS       = 8;
    localparam int OWT_FRAME_BITS     = 14;

endpackage

/* hdl/hv_digital_top.sv */
// module: high-voltage side digital top, receiver, self test, arbiter and bank
`timescale 1ns/1ps

module hv_digital_top (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_owt_rx,
    input  logic i_bist_en,
    output logic o_owt_bist_fail,
    output logic o_scan_bist_fail,
    output logic o_bist_done,
    output logic o_rx_done,
    output logic o_rx_bad
);

    // register access buses
    hv_reg_if owt_if  ();
    hv_reg_if bist_if ();
    hv_reg_if bank_if ();

    hv_owt_rx hv_owt_rx_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_owt_rx  (i_owt_rx),
        .o_rx_done (o_rx_done),
        .o_rx_bad  (o_rx_bad),
        .wr        (owt_if.requester)
    );

    // frame status also feeds the link count
    hv_lbist hv_lbist_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_bist_en        (i_bist_en),
        .i_owt_rx_ack     (o_rx_done),
        .i_owt_rx_status  (o_rx_bad),
        .scan             (bist_if.requester),
        .o_owt_bist_fail  (o_owt_bist_fail),
        .o_scan_bist_fail (o_scan_bist_fail),
        .o_bist_done      (o_bist_done)
    );

    // m0 receiver, m1 self test
    hv_reg_arb hv_reg_arb_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .m0      (owt_if.responder),
        .m1      (bist_if.responder),
        .bank    (bank_if.requester)
    );

    hv_reg_bank hv_reg_bank_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (bank_if.responder)
    );

endmodule

/* hdl/hv_lbist.sv */
// module: logic self test, register integrity scan and link frame count
`timescale 1ns/1ps

module hv_lbist (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_bist_en,
    input  logic        i_owt_rx_ack,
    input  logic        i_owt_rx_status,
    hv_reg_if.requester scan,
    output logic        o_owt_bist_fail,
    output logic        o_scan_bist_fail,
    output logic        o_bist_done
);

    localparam int REG_NUM    = hv_cfg_pkg::HV_SCAN_REG_NUM;
    localparam int SCAN_CNT_W = $clog2(REG_NUM + 1);
    localparam int TMO_W      = hv_cfg_pkg::BIST_TMO_CNT_W;
    localparam int OK_W       = hv_cfg_pkg::BIST_OWT_RX_CNT_W;
    localparam logic [SCAN_CNT_W-1:0] SCAN_END = SCAN_CNT_W'(REG_NUM);
    localparam logic [TMO_W-1:0]      TMO_END  = TMO_W'(hv_cfg_pkg::BIST_TMO_TH - 1);
    localparam logic [OK_W-1:0]       OK_MIN   = OK_W'(hv_cfg_pkg::BIST_OWT_RX_OK_NUM);

    logic [SCAN_CNT_W-1:0] scan_cnt;
    logic                  scan_err;
    logic [TMO_W-1:0]      tmo_cnt;
    logic [OK_W-1:0]       rx_ok_cnt;
    logic                  win_end;
    logic                  rx_ok;

    // window counter saturates at its end value
    assign win_end = (tmo_cnt == TMO_END);
    assign rx_ok   = i_owt_rx_ack && !i_owt_rx_status && !win_end;

    // ====================
    // register scan
    // ====================
    // one read per register, sticky error on rerr
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan.req <= 1'b0;
            scan_cnt <= '0;
            scan_err <= 1'b0;
        end else if (!i_bist_en) begin
            scan.req <= 1'b0;
            scan_cnt <= '0;
            scan_err <= 1'b0;
        end else if (scan.req && scan.ack) begin
            scan.req <= 1'b0;
            scan_cnt <= scan_cnt + 1'b1;
            scan_err <= scan_err | scan.rerr;
        end else if (!scan.req && !scan.ack && (scan_cnt != SCAN_END)) begin
            scan.req <= 1'b1;
        end
    end

    assign scan.cmd = '{we: 1'b0, addr: scan_cnt[hv_reg_pkg::REG_ADDR_W-1:0],
                        wdata: '0, wchk: 1'b0};

    // ====================
    // link window
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmo_cnt   <= '0;
            rx_ok_cnt <= '0;
        end else if (!i_bist_en) begin
            tmo_cnt   <= '0;
            rx_ok_cnt <= '0;
        end else begin
            if (!win_end) begin
                tmo_cnt <= tmo_cnt + 1'b1;
            end
            if (rx_ok && (rx_ok_cnt != '1)) begin
                rx_ok_cnt <= rx_ok_cnt + 1'b1;
            end
        end
    end

    // results latch with done and hold while enabled
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bist_done      <= 1'b0;
            o_owt_bist_fail  <= 1'b0;
            o_scan_bist_fail <= 1'b0;
        end else if (!i_bist_en) begin
            o_bist_done      <= 1'b0;
            o_owt_bist_fail  <= 1'b0;
            o_scan_bist_fail <= 1'b0;
        end else if (win_end) begin
            o_bist_done      <= 1'b1;
            o_owt_bist_fail  <= (rx_ok_cnt < OK_MIN);
            o_scan_bist_fail <= scan_err;
        end
    end

endmodule

/* hdl/hv_owt_rx.sv */
// module: one-wire frame receiver issuing register writes for good frames
`timescale 1ns/1ps

module hv_owt_rx (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_owt_rx,
    output logic        o_rx_done,
    output logic        o_rx_bad,
    hv_reg_if.requester wr
);

    localparam int BIT_CLKS  = hv_cfg_pkg::OWT_BIT_CLKS;
    localparam int CLK_CNT_W = $clog2(2 * BIT_CLKS);
    localparam int BIT_CNT_W = $clog2(hv_cfg_pkg::OWT_FRAME_BITS);
    // addr, data, chk and parity, the stop bit is checked live
    localparam int SHIFT_W   = hv_cfg_pkg::OWT_FRAME_BITS - 1;
    localparam int ADDR_W    = hv_reg_pkg::REG_ADDR_W;
    localparam int DATA_W    = hv_reg_pkg::REG_DATA_W;
    // first sample sits in the middle of the first field bit
    localparam logic [CLK_CNT_W-1:0] FIRST_WAIT = CLK_CNT_W'(BIT_CLKS + BIT_CLKS / 2 - 1);
    localparam logic [CLK_CNT_W-1:0] BIT_WAIT   = CLK_CNT_W'(BIT_CLKS - 1);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT   = BIT_CNT_W'(hv_cfg_pkg::OWT_FRAME_BITS - 1);

    logic                 rx_s1;
    logic                 rx_s2;
    logic                 rx_d;
    logic                 busy;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [SHIFT_W-1:0]   shift_q;
    logic                 sample;
    logic                 frame_end;
    logic                 frame_bad;
    logic                 wr_go;
    hv_reg_pkg::reg_cmd_t cmd_q;

    // line synchronizer, idles high
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_d  <= 1'b1;
        end else begin
            rx_s1 <= i_owt_rx;
            rx_s2 <= rx_s1;
            rx_d  <= rx_s2;
        end
    end

    assign sample    = busy && (clk_cnt == '0);
    assign frame_end = sample && (bit_cnt == LAST_BIT);
    // even parity over all shifted fields, then stop must be high
    assign frame_bad = (^shift_q) || !rx_s2;
    assign wr_go     = frame_end && !frame_bad && !wr.req && !wr.ack;

    // ====================
    // bit timing
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            // falling edge starts a frame
            if (rx_d && !rx_s2) begin
                busy    <= 1'b1;
                clk_cnt <= FIRST_WAIT;
                bit_cnt <= '0;
            end
        end else if (sample) begin
            clk_cnt <= BIT_WAIT;
            bit_cnt <= bit_cnt + 1'b1;
            if (frame_end) begin
                busy <= 1'b0;
            end
        end else begin
            clk_cnt <= clk_cnt - 1'b1;
        end
    end

    // msb first
    always_ff @(posedge i_clk) begin
        if (sample) begin
            shift_q <= {shift_q[SHIFT_W-2:0], rx_s2};
        end
    end

    // frame status, done pulses in the stop bit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx_done <= 1'b0;
            o_rx_bad  <= 1'b0;
        end else begin
            o_rx_done <= frame_end;
            if (frame_end) begin
                o_rx_bad <= frame_bad;
            end
        end
    end

    // ====================
    // register write
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr.req <= 1'b0;
        end else if (wr.req && wr.ack) begin
            wr.req <= 1'b0;
        end else if (wr_go) begin
            wr.req <= 1'b1;
        end
    end

    // single frame buffer, dropped if a write is still pending
    always_ff @(posedge i_clk) begin
        if (wr_go) begin
            cmd_q.we    <= 1'b1;
            cmd_q.addr  <= shift_q[SHIFT_W-1 -: ADDR_W];
            cmd_q.wdata <= shift_q[SHIFT_W-1-ADDR_W -: DATA_W];
            cmd_q.wchk  <= shift_q[1];
        end
    end

    assign wr.cmd = cmd_q;

endmodule

/* hdl/hv_reg_arb.sv */
// module: two-requester arbiter with alternating priority for the register bank
`timescale 1ns/1ps

module hv_reg_arb (
    input  logic        i_clk,
    input  logic        i_rst_n,
    hv_reg_if.responder m0,
    hv_reg_if.responder m1,
    hv_reg_if.requester bank
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FWD,
        ARB_REL
    } arb_state_t;

    arb_state_t                        state;
    // current or last winner, 1 is m1
    logic                              sel;
    logic                              sel_req;
    logic                              ack_q;
    logic [hv_reg_pkg::REG_DATA_W-1:0] rdata_q;
    logic                              rerr_q;

    assign sel_req = sel ? m1.req : m0.req;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ARB_IDLE;
            sel      <= 1'b0;
            bank.req <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if ((m0.req || m1.req) && !bank.ack) begin
                        // tie goes to whoever lost last time
                        sel      <= (m0.req && m1.req) ? !sel : m1.req;
                        bank.req <= 1'b1;
                        state    <= ARB_FWD;
                    end
                end
                ARB_FWD: begin
                    ack_q    <= bank.ack;
                    bank.req <= sel_req;
                    if (!sel_req) begin
                        state <= ARB_REL;
                    end
                end
                ARB_REL: begin
                    // hold grant until the bank lets go
                    ack_q <= bank.ack;
                    if (!bank.ack) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (bank.ack) begin
            rdata_q <= bank.rdata;
            rerr_q  <= bank.rerr;
        end
    end

    assign bank.cmd = sel ? m1.cmd : m0.cmd;

    // response to the winner only
    assign m0.ack   = ack_q && !sel;
    assign m0.rdata = sel ? '0 : rdata_q;
    assign m0.rerr  = !sel && rerr_q;
    assign m1.ack   = ack_q && sel;
    assign m1.rdata = sel ? rdata_q : '0;
    assign m1.rerr  = sel && rerr_q;

endmodule

/* hdl/hv_reg_bank.sv */
// module: protected register storage with check bits, serving reads and writes
`timescale 1ns/1ps

module hv_reg_bank (
    input  logic        i_clk,
    input  logic        i_rst_n,
    hv_reg_if.responder bus
);

    localparam int REG_NUM = hv_cfg_pkg::HV_SCAN_REG_NUM;
    localparam int DATA_W  = hv_reg_pkg::REG_DATA_W;

    logic [DATA_W-1:0] reg_data [REG_NUM];
    logic              reg_chk  [REG_NUM];
    logic              access;

    // first cycle of a request only
    assign access = bus.req && !bus.ack;

    // ====================
    // storage
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // all zero is a consistent pattern
            for (int i = 0; i < REG_NUM; i++) begin
                reg_data[i] <= '0;
                reg_chk[i]  <= 1'b0;
            end
        end else if (access && bus.cmd.we) begin
            reg_data[bus.cmd.addr] <= bus.cmd.wdata;
            reg_chk[bus.cmd.addr]  <= bus.cmd.wchk;
        end
    end

    // ====================
    // handshake
    // ====================
    // ack follows req by one cycle both ways
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req;
        end
    end

    // read data and integrity check of the stored word
    always_ff @(posedge i_clk) begin
        if (access) begin
            bus.rdata <= reg_data[bus.cmd.addr];
            bus.rerr  <= reg_chk[bus.cmd.addr] ^ (^reg_data[bus.cmd.addr]);
        end
    end

endmodule

/* hdl/hv_reg_if.sv */
// interface: four-phase register access bus with requester and responder views
`timescale 1ns/1ps

interface hv_reg_if;

    // requester side, cmd stable while req is high
    logic                              req;
    hv_reg_pkg::reg_cmd_t              cmd;

    // responder side, rdata and rerr valid while ack is high
    logic                              ack;
    logic [hv_reg_pkg::REG_DATA_W-1:0] rdata;
    logic                              rerr;

    modport requester (output req, output cmd, input ack, input rdata, input rerr);

    modport responder (input req, input cmd, output ack, output rdata, output rerr);

endinterface

/* hdl/hv_reg_pkg.sv */
// package: register map sizes and the register access command
package hv_reg_pkg;

    // ====================
    // register map
    // ====================
    localparam int REG_ADDR_W = 3;
    localparam int REG_DATA_W = 8;

    // ====================
    // access command
    // ====================
    // one request on the register bus, 13 bits
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] wdata;
        // host-supplied check bit, stored as is
        logic                  wchk;
    } reg_cmd_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, exit status 1 on any failure

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_hv_digital \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
